// File: mem_pipe.f
+incdir+verilog
verilog/lsu_pkg.sv
verilog/wb_bus_pkg.sv
verilog/lane_steer.sv
verilog/mem_stage.sv
verilog/wb_stage.sv
verilog/data_ram.sv
verilog/mem_pipe_top.sv
verification/tb_mem_pipe.sv

// File: verification/tb_mem_pipe.sv
`timescale 1ns/10ps
`include "mem_pipe_config.svh"

module tb_mem_pipe import lsu_pkg::*; ();

    localparam int N_OPS          = 400;
    localparam int TIMEOUT_CYCLES = 20 * N_OPS + 100;

    typedef struct packed {
        logic [31:0] pc;
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic        adem;
        logic        bus;
        mem_op_t     op;
        logic [31:0] tick;
    } retire_t;

    logic                   clk;
    logic                   arst_n;
    logic                   flush;
    logic                   in_valid;
    logic [`MP_XLEN-1:0]    in_pc;
    logic [`MP_XLEN-1:0]    in_alu_result;
    logic [`MP_XLEN-1:0]    in_store_data;
    mem_op_t                in_op;
    logic [`MP_RADDR_W-1:0] in_dest;
    logic                   in_gr_we;
    logic                   mem_allow_in;
    logic                   wb_valid;
    logic [`MP_XLEN-1:0]    wb_pc;
    logic                   rf_we;
    logic [`MP_RADDR_W-1:0] rf_waddr;
    logic [`MP_XLEN-1:0]    rf_wdata;
    logic                   wb_ex_adem;
    logic [`MP_RADDR_W-1:0] mem_forward_dest;
    logic [`MP_XLEN-1:0]    mem_forward_data;

    // Byte image of the data RAM
    logic [7:0]             model_mem [0:`MP_RAM_WORDS*4-1];
    retire_t                exp_q [$];
    int                     errors = 0;
    int                     issued = 0;
    int                     retired = 0;
    int                     flushes = 0;
    int                     tick = 0;
    int                     cycles = 0;
    // 0 idle, 1 OP_NONE, 2 bus op, 3 misaligned access
    int                     last_kind = 0;
    logic [`MP_RADDR_W-1:0] last_dest;
    logic [`MP_XLEN-1:0]    last_alu;
    // Set while a load or store sits in MEM or its bus cycle is pending
    logic                   bus_busy = 1'b0;
    int                     leave_tick = -1;

    mem_pipe_top u_dut (
        .clk              (clk),
        .arst_n           (arst_n),
        .flush            (flush),
        .in_valid         (in_valid),
        .in_pc            (in_pc),
        .in_alu_result    (in_alu_result),
        .in_store_data    (in_store_data),
        .in_op            (in_op),
        .in_dest          (in_dest),
        .in_gr_we         (in_gr_we),
        .mem_allow_in     (mem_allow_in),
        .wb_valid         (wb_valid),
        .wb_pc            (wb_pc),
        .rf_we            (rf_we),
        .rf_waddr         (rf_waddr),
        .rf_wdata         (rf_wdata),
        .wb_ex_adem       (wb_ex_adem),
        .mem_forward_dest (mem_forward_dest),
        .mem_forward_data (mem_forward_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d operations outstanding",
                     cycles, exp_q.size());
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ******************************
    // Reference model
    // ******************************

    // Little endian lanes, sign or zero extension by opcode
    function automatic logic [31:0] model_load(input mem_op_t op, input int a);
        case (op)
            OP_LD_B:  return {{24{model_mem[a][7]}}, model_mem[a]};
            OP_LD_BU: return {24'h0, model_mem[a]};
            OP_LD_H:  return {{16{model_mem[a+1][7]}}, model_mem[a+1], model_mem[a]};
            OP_LD_HU: return {16'h0, model_mem[a+1], model_mem[a]};
            default:  return {model_mem[a+3], model_mem[a+2], model_mem[a+1], model_mem[a]};
        endcase
    endfunction

    task automatic model_store(input mem_op_t op, input int a, input logic [31:0] d);
        model_mem[a] = d[7:0];
        if (op != OP_ST_B) begin
            model_mem[a+1] = d[15:8];
        end
        if (op == OP_ST_W) begin
            model_mem[a+2] = d[23:16];
            model_mem[a+3] = d[31:24];
        end
    endtask

    function automatic string test_name(input mem_op_t op, input logic adem);
        if (op == OP_NONE) begin
            return "alu_pass";
        end else if (adem) begin
            return "misaligned";
        end else if (op inside {OP_ST_B, OP_ST_H, OP_ST_W}) begin
            return "store";
        end
        return "load";
    endfunction

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("Mismatch %s %s: expected %h, actual %h", name, field, exp, act);
    endtask

    // ******************************
    // Stimulus
    // ******************************

    task automatic issue_op();
        retire_t     rec;
        mem_op_t     op;
        int          kind;
        int          word;
        int          off;
        logic        is_ld;
        logic        is_st;
        logic [31:0] addr;

        kind = $urandom % 10;
        if (kind < 3) begin
            op = OP_NONE;
        end else if (kind < 7) begin
            op = mem_op_t'(1 + $urandom % 5);
        end else begin
            op = mem_op_t'(6 + $urandom % 3);
        end
        is_ld = op inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W};
        is_st = op inside {OP_ST_B, OP_ST_H, OP_ST_W};

        // Mostly a small window so loads hit earlier stores
        word = ($urandom % 8 == 0) ? $urandom % `MP_RAM_WORDS : $urandom % 16;
        off  = $urandom % 4;
        if ($urandom % 2 == 1) begin
            off = (op inside {OP_LD_H, OP_LD_HU, OP_ST_H}) ? (off & 2) : 0;
        end
        addr = word * 4 + off;

        in_valid      = 1'b1;
        in_pc         = 32'h1000 + issued * 4;
        in_op         = op;
        in_alu_result = (op == OP_NONE) ? $urandom : addr;
        in_store_data = $urandom;
        in_dest       = $urandom % 32;
        in_gr_we      = is_st ? 1'b0 : ((op == OP_NONE) ? ($urandom % 2 == 1) : 1'b1);

        if (op inside {OP_LD_H, OP_LD_HU, OP_ST_H}) begin
            rec.adem = (off % 2 == 1);
        end else if (op inside {OP_LD_W, OP_ST_W}) begin
            rec.adem = (off != 0);
        end else begin
            rec.adem = 1'b0;
        end
        rec.bus   = (is_ld || is_st) && !rec.adem;
        rec.pc    = in_pc;
        rec.op    = op;
        rec.tick  = tick;
        rec.we    = in_gr_we && !rec.adem && (in_dest != 0);
        rec.waddr = in_dest;
        rec.wdata = (is_ld && !rec.adem) ? model_load(op, addr) : in_alu_result;
        if (rec.bus && is_st) begin
            model_store(op, addr, in_store_data);
        end
        exp_q.push_back(rec);

        last_kind = rec.bus ? 2 : ((op == OP_NONE) ? 1 : 3);
        last_dest = in_dest;
        last_alu  = in_alu_result;
        if (rec.bus) begin
            bus_busy = 1'b1;
        end
        issued++;
    endtask

    // ******************************
    // Checks
    // ******************************

    task automatic check_retire();
        retire_t rec;
        string   name;

        if (exp_q.size() == 0) begin
            errors++;
            $display("WB retired pc %h with no operation outstanding", wb_pc);
        end else begin
            rec  = exp_q.pop_front();
            name = test_name(rec.op, rec.adem);
            retired++;
            if (wb_pc !== rec.pc) report_mismatch(name, "pc", rec.pc, wb_pc);
            if (rf_we !== rec.we) report_mismatch(name, "rf_we", rec.we, rf_we);
            if (wb_ex_adem !== rec.adem) report_mismatch(name, "adem", rec.adem, wb_ex_adem);
            if (rec.we && rf_waddr !== rec.waddr) begin
                report_mismatch(name, "rf_waddr", rec.waddr, rf_waddr);
            end
            if (rec.we && rf_wdata !== rec.wdata) begin
                report_mismatch(name, "rf_wdata", rec.wdata, rf_wdata);
            end
            if (!rec.bus && tick - rec.tick != 2) begin
                errors++;
                $display("%s op at pc %h retired after %0d cycles instead of 2",
                         name, rec.pc, tick - rec.tick);
            end
            if (rec.bus && leave_tick != tick - 1) begin
                errors++;
                $display("%s op at pc %h retired without mem_allow_in rising the cycle before",
                         name, rec.pc);
            end
        end
    endtask

    task automatic check_mem_side();
        if (last_kind == 1) begin
            if (mem_forward_dest !== last_dest) begin
                report_mismatch("forwarding", "dest", last_dest, mem_forward_dest);
            end
            if (mem_forward_data !== last_alu) begin
                report_mismatch("forwarding", "data", last_alu, mem_forward_data);
            end
        end else if (last_kind == 0 && !bus_busy && mem_forward_dest !== '0) begin
            report_mismatch("forwarding", "dest while empty", 0, mem_forward_dest);
        end
        if (last_kind == 2 && mem_allow_in !== 1'b0) begin
            errors++;
            $display("mem_allow_in high while a bus cycle is pending");
        end
        if ((last_kind == 1 || last_kind == 3) && mem_allow_in !== 1'b1) begin
            errors++;
            $display("mem_allow_in low after a single-cycle operation");
        end
        // A load or store leaves MEM in the cycle allow-in comes back
        if (bus_busy && mem_allow_in === 1'b1) begin
            bus_busy   = 1'b0;
            leave_tick = tick;
        end
    endtask

    initial begin
        int roll;

        void'($urandom(74));
        arst_n        = 1'b0;
        flush         = 1'b0;
        in_valid      = 1'b0;
        in_pc         = '0;
        in_alu_result = '0;
        in_store_data = '0;
        in_op         = OP_NONE;
        in_dest       = '0;
        in_gr_we      = 1'b0;
        for (int i = 0; i < `MP_RAM_WORDS * 4; i++) begin
            model_mem[i] = 8'h00;
        end
        repeat (4) @(negedge clk);
        arst_n = 1'b1;

        while (issued < N_OPS || exp_q.size() > 0) begin
            @(negedge clk);
            tick++;
            if (wb_valid === 1'b1) begin
                check_retire();
            end
            check_mem_side();
            in_valid  = 1'b0;
            flush     = 1'b0;
            last_kind = 0;
            roll      = $urandom % 25;
            if (issued < N_OPS && roll == 0) begin
                // Everything still in flight is dropped
                flush = 1'b1;
                flushes++;
                exp_q.delete();
            end else if (issued < N_OPS && roll != 1 && mem_allow_in === 1'b1) begin
                issue_op();
            end
        end

        repeat (4) begin
            @(negedge clk);
            if (wb_valid !== 1'b0) begin
                errors++;
                $display("WB retired an operation after all expected results were seen");
            end
        end

        $display("Issued %0d, retired %0d, flushes %0d, errors %0d",
                 issued, retired, flushes, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/data_ram.sv
`timescale 1ns/10ps
`include "mem_pipe_config.svh"

module data_ram import wb_bus_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`MP_XLEN-3:0]    wb_adr,
    input  logic [`MP_XLEN-1:0]    wb_dat_w,
    input  logic [`MP_XLEN/8-1:0]  wb_sel,
    output logic [`MP_XLEN-1:0]    wb_dat_r,
    output logic                   wb_ack
);

    localparam int IDX_W = $clog2(`MP_RAM_WORDS);
    localparam int CNT_W = $clog2(`MP_RAM_WAIT + 1);

    logic [`MP_XLEN-1:0] mem [`MP_RAM_WORDS];
    logic [IDX_W-1:0]    idx;
    logic [CNT_W-1:0]    cnt;
    bus_state_t          phase;

    assign idx      = wb_adr[IDX_W-1:0];
    assign wb_ack   = (phase == BUS_DONE);
    assign wb_dat_r = mem[idx];

    // ******************************
    // Wait counter
    // ******************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= BUS_IDLE;
            cnt   <= '0;
        end else begin
            case (phase)
                BUS_IDLE: begin
                    if (wb_cyc && wb_stb) begin
                        cnt   <= CNT_W'(1);
                        phase <= (`MP_RAM_WAIT <= 1) ? BUS_DONE : BUS_WAIT;
                    end
                end
                BUS_WAIT: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(`MP_RAM_WAIT - 1)) begin
                        phase <= BUS_DONE;
                    end
                end
                default: begin
                    phase <= BUS_IDLE;
                end
            endcase
        end
    end

    // Byte writes land on the ack edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `MP_RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wb_ack && wb_we) begin
            for (int b = 0; b < `MP_XLEN / 8; b++) begin
                if (wb_sel[b]) begin
                    mem[idx][8*b +: 8] <= wb_dat_w[8*b +: 8];
                end
            end
        end
    end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        wb_ack |-> wb_cyc && wb_stb)
        else $error("ack without an active request");

endmodule

// File: verilog/lane_steer.sv
`timescale 1ns/10ps
`include "mem_pipe_config.svh"

module lane_steer import lsu_pkg::*; (
    input  mem_op_t                op,
    input  logic [1:0]             byte_off,
    input  logic [`MP_XLEN-1:0]    store_data,
    input  logic [`MP_XLEN-1:0]    load_word,
    output logic [`MP_XLEN/8-1:0]  sel,
    output logic [`MP_XLEN-1:0]    store_lanes,
    output logic [`MP_XLEN-1:0]    load_data,
    output logic                   misaligned
);

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    // ******************************
    // Store side
    // ******************************

    always_comb begin
        sel         = '0;
        store_lanes = store_data;
        misaligned  = 1'b0;
        case (op)
            OP_LD_B, OP_LD_BU, OP_ST_B: begin
                sel         = 4'b0001 << byte_off;
                store_lanes = {(`MP_XLEN/8){store_data[7:0]}};
            end
            OP_LD_H, OP_LD_HU, OP_ST_H: begin
                sel         = byte_off[1] ? 4'b1100 : 4'b0011;
                store_lanes = {(`MP_XLEN/16){store_data[15:0]}};
                misaligned  = byte_off[0];
            end
            OP_LD_W, OP_ST_W: begin
                sel        = 4'b1111;
                misaligned = |byte_off;
            end
            default: begin
                // No memory access, selects stay low
                sel = '0;
            end
        endcase
    end

    // ******************************
    // Load side
    // ******************************

    // Halfword offset only uses bit 1, odd offsets are caught above
    assign ld_byte = load_word[{byte_off, 3'b000} +: 8];
    assign ld_half = load_word[{byte_off[1], 4'b0000} +: 16];

    always_comb begin
        case (op)
            OP_LD_B:  load_data = {{(`MP_XLEN-8){ld_byte[7]}}, ld_byte};
            OP_LD_BU: load_data = {{(`MP_XLEN-8){1'b0}}, ld_byte};
            OP_LD_H:  load_data = {{(`MP_XLEN-16){ld_half[15]}}, ld_half};
            OP_LD_HU: load_data = {{(`MP_XLEN-16){1'b0}}, ld_half};
            default:  load_data = load_word;
        endcase
    end

endmodule

// File: verilog/lsu_pkg.sv
package lsu_pkg;

    // ******************************
    // Memory opcodes
    // ******************************

    // OP_NONE passes the ALU result through
    typedef enum logic [3:0] {
        OP_NONE  = 4'd0,

        // Loads, signed and unsigned
        OP_LD_B  = 4'd1,
        OP_LD_BU = 4'd2,
        OP_LD_H  = 4'd3,
        OP_LD_HU = 4'd4,
        OP_LD_W  = 4'd5,

        // Stores
        OP_ST_B  = 4'd6,
        OP_ST_H  = 4'd7,
        OP_ST_W  = 4'd8
    } mem_op_t;

endpackage

// File: verilog/mem_pipe_config.svh
`ifndef MEM_PIPE_CONFIG_SVH
`define MEM_PIPE_CONFIG_SVH

// ******************************
// Datapath widths
// ******************************

`define MP_XLEN      32
`define MP_RADDR_W   5

// ******************************
// Data RAM
// ******************************

// Depth in 32-bit words
`define MP_RAM_WORDS 256

// Cycles from first stb to ack, at least one
`define MP_RAM_WAIT  1

`endif

// File: verilog/mem_pipe_top.sv
`timescale 1ns/10ps
`include "mem_pipe_config.svh"

module mem_pipe_top import lsu_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flush,
    input  logic                   in_valid,
    input  logic [`MP_XLEN-1:0]    in_pc,
    input  logic [`MP_XLEN-1:0]    in_alu_result,
    input  logic [`MP_XLEN-1:0]    in_store_data,
    input  mem_op_t                in_op,
    input  logic [`MP_RADDR_W-1:0] in_dest,
    input  logic                   in_gr_we,
    output logic                   mem_allow_in,
    output logic                   wb_valid,
    output logic [`MP_XLEN-1:0]    wb_pc,
    output logic                   rf_we,
    output logic [`MP_RADDR_W-1:0] rf_waddr,
    output logic [`MP_XLEN-1:0]    rf_wdata,
    output logic                   wb_ex_adem,
    output logic [`MP_RADDR_W-1:0] mem_forward_dest,
    output logic [`MP_XLEN-1:0]    mem_forward_data
);

    // MEM to WB
    logic                   m2w_valid;
    logic [`MP_XLEN-1:0]    m2w_pc;
    logic [`MP_XLEN-1:0]    m2w_result;
    logic [`MP_RADDR_W-1:0] m2w_dest;
    logic                   m2w_gr_we;
    logic                   m2w_ex_adem;

    // Data bus
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`MP_XLEN-3:0]    wb_adr;
    logic [`MP_XLEN-1:0]    wb_dat_w;
    logic [`MP_XLEN/8-1:0]  wb_sel;
    logic [`MP_XLEN-1:0]    wb_dat_r;
    logic                   wb_ack;

    mem_stage u_mem_stage (
        .clk              (clk),
        .arst_n           (arst_n),
        .flush            (flush),
        .in_valid         (in_valid),
        .in_pc            (in_pc),
        .in_alu_result    (in_alu_result),
        .in_store_data    (in_store_data),
        .in_op            (in_op),
        .in_dest          (in_dest),
        .in_gr_we         (in_gr_we),
        .mem_allow_in     (mem_allow_in),
        .mem_to_wb_valid  (m2w_valid),
        .out_pc           (m2w_pc),
        .out_result       (m2w_result),
        .out_dest         (m2w_dest),
        .out_gr_we        (m2w_gr_we),
        .out_ex_adem      (m2w_ex_adem),
        .wb_cyc           (wb_cyc),
        .wb_stb           (wb_stb),
        .wb_we            (wb_we),
        .wb_adr           (wb_adr),
        .wb_dat_w         (wb_dat_w),
        .wb_sel           (wb_sel),
        .wb_dat_r         (wb_dat_r),
        .wb_ack           (wb_ack),
        .mem_forward_dest (mem_forward_dest),
        .mem_forward_data (mem_forward_data)
    );

    wb_stage u_wb_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .in_valid   (m2w_valid),
        .in_pc      (m2w_pc),
        .in_result  (m2w_result),
        .in_dest    (m2w_dest),
        .in_gr_we   (m2w_gr_we),
        .in_ex_adem (m2w_ex_adem),
        .wb_valid   (wb_valid),
        .wb_pc      (wb_pc),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .wb_ex_adem (wb_ex_adem)
    );

    data_ram u_data_ram (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

endmodule

// File: verilog/mem_stage.sv
`timescale 1ns/10ps
`include "mem_pipe_config.svh"

module mem_stage import lsu_pkg::*; import wb_bus_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flush,
    input  logic                   in_valid,
    input  logic [`MP_XLEN-1:0]    in_pc,
    input  logic [`MP_XLEN-1:0]    in_alu_result,
    input  logic [`MP_XLEN-1:0]    in_store_data,
    input  mem_op_t                in_op,
    input  logic [`MP_RADDR_W-1:0] in_dest,
    input  logic                   in_gr_we,
    output logic                   mem_allow_in,
    output logic                   mem_to_wb_valid,
    output logic [`MP_XLEN-1:0]    out_pc,
    output logic [`MP_XLEN-1:0]    out_result,
    output logic [`MP_RADDR_W-1:0] out_dest,
    output logic                   out_gr_we,
    output logic                   out_ex_adem,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic                   wb_we,
    output logic [`MP_XLEN-3:0]    wb_adr,
    output logic [`MP_XLEN-1:0]    wb_dat_w,
    output logic [`MP_XLEN/8-1:0]  wb_sel,
    input  logic [`MP_XLEN-1:0]    wb_dat_r,
    input  logic                   wb_ack,
    output logic [`MP_RADDR_W-1:0] mem_forward_dest,
    output logic [`MP_XLEN-1:0]    mem_forward_data
);

    logic                   mem_valid;
    logic                   ready_go;
    logic [`MP_XLEN-1:0]    pc_q;
    logic [`MP_XLEN-1:0]    alu_q;
    logic [`MP_XLEN-1:0]    sdata_q;
    logic [`MP_XLEN-1:0]    rdata_q;
    mem_op_t                op_q;
    logic [`MP_RADDR_W-1:0] dest_q;
    logic                   gr_we_q;
    bus_state_t             bus_state;
    logic                   is_load;
    logic                   is_store;
    logic                   need_bus;
    logic                   bus_req;
    logic                   misaligned;
    logic [`MP_XLEN-1:0]    load_data;
    logic [`MP_XLEN-1:0]    final_result;

    // ******************************
    // Pipeline register
    // ******************************

    // Bus wait blocks new work even after a flush empties the stage
    assign ready_go        = ~need_bus | (bus_state == BUS_DONE);
    assign mem_allow_in    = (bus_state != BUS_WAIT) & (~mem_valid | ready_go);
    assign mem_to_wb_valid = mem_valid & ready_go;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_valid <= 1'b0;
        end else if (flush) begin
            mem_valid <= 1'b0;
        end else if (mem_allow_in) begin
            mem_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && mem_allow_in) begin
            pc_q    <= in_pc;
            alu_q   <= in_alu_result;
            sdata_q <= in_store_data;
            op_q    <= in_op;
            dest_q  <= in_dest;
            gr_we_q <= in_gr_we;
        end
    end

    lane_steer u_lane_steer (
        .op          (op_q),
        .byte_off    (alu_q[1:0]),
        .store_data  (sdata_q),
        .load_word   (rdata_q),
        .sel         (wb_sel),
        .store_lanes (wb_dat_w),
        .load_data   (load_data),
        .misaligned  (misaligned)
    );

    // ******************************
    // Wishbone master
    // ******************************

    assign is_load  = op_q inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W};
    assign is_store = op_q inside {OP_ST_B, OP_ST_H, OP_ST_W};
    assign need_bus = (is_load | is_store) & ~misaligned;
    assign bus_req  = mem_valid & need_bus & (bus_state == BUS_IDLE);

    // stb follows the FSM once started, so a flush cannot cut a cycle short
    assign wb_stb = bus_req | (bus_state == BUS_WAIT);
    // cyc also covers the cycle that registers the read data
    assign wb_cyc = wb_stb | (bus_state == BUS_DONE);
    assign wb_we  = is_store;
    assign wb_adr = alu_q[`MP_XLEN-1:2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_state <= BUS_IDLE;
        end else begin
            case (bus_state)
                BUS_IDLE: begin
                    if (bus_req) begin
                        bus_state <= wb_ack ? BUS_DONE : BUS_WAIT;
                    end
                end
                BUS_WAIT: begin
                    if (wb_ack) begin
                        bus_state <= BUS_DONE;
                    end
                end
                default: begin
                    bus_state <= BUS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wb_stb && wb_ack) begin
            rdata_q <= wb_dat_r;
        end
    end

    // ******************************
    // Results and forwarding
    // ******************************

    assign final_result = is_load ? load_data : alu_q;

    assign out_pc      = pc_q;
    assign out_result  = final_result;
    assign out_dest    = dest_q;
    assign out_gr_we   = gr_we_q;
    assign out_ex_adem = misaligned;

    assign mem_forward_dest = dest_q & {`MP_RADDR_W{mem_valid}};
    assign mem_forward_data = final_result;

    // Request held steady until the slave acks
    a_stb_hold: assert property (@(posedge clk) disable iff (!arst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable({wb_we, wb_adr, wb_dat_w, wb_sel}))
        else $error("bus request changed before ack");

endmodule

// File: verilog/wb_bus_pkg.sv
package wb_bus_pkg;

    // ******************************
    // Wishbone cycle phase
    // ******************************

    // Shared by the master FSM and the RAM wait counter
    typedef enum logic [1:0] {
        BUS_IDLE = 2'd0,
        BUS_WAIT = 2'd1,
        BUS_DONE = 2'd2
    } bus_state_t;

endpackage

// File: verilog/wb_stage.sv
`timescale 1ns/10ps
`include "mem_pipe_config.svh"

module wb_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flush,
    input  logic                   in_valid,
    input  logic [`MP_XLEN-1:0]    in_pc,
    input  logic [`MP_XLEN-1:0]    in_result,
    input  logic [`MP_RADDR_W-1:0] in_dest,
    input  logic                   in_gr_we,
    input  logic                   in_ex_adem,
    output logic                   wb_valid,
    output logic [`MP_XLEN-1:0]    wb_pc,
    output logic                   rf_we,
    output logic [`MP_RADDR_W-1:0] rf_waddr,
    output logic [`MP_XLEN-1:0]    rf_wdata,
    output logic                   wb_ex_adem
);

    logic [`MP_XLEN-1:0]    result_q;
    logic [`MP_RADDR_W-1:0] dest_q;
    logic                   gr_we_q;
    logic                   adem_q;

    // Always accepts, so only flush can drop an operation here
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else if (flush) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            wb_pc    <= in_pc;
            result_q <= in_result;
            dest_q   <= in_dest;
            gr_we_q  <= in_gr_we;
            adem_q   <= in_ex_adem;
        end
    end

    // ******************************
    // Register file port
    // ******************************

    // r0 is hardwired, faulting ops never write
    assign rf_we      = wb_valid & gr_we_q & ~adem_q & (|dest_q);
    assign rf_waddr   = dest_q;
    assign rf_wdata   = result_q;
    assign wb_ex_adem = wb_valid & adem_q;

endmodule
